// File: all.f
common/mipsPkg.sv
source/controlUnit.sv
source/alu.sv
source/regFile.sv
source/pcUnit.sv
source/mipsCore.sv
dv/mipsTb.sv

// File: common/mipsPkg.sv
/* MIPS shared definitions
   opcodes, function codes, ALU operations, control bundle and instruction layouts */
`default_nettype none

package mipsPkg;

  // ==============================
  // opcode field values
  // ==============================
  localparam logic [5:0] opR   = 6'b000000;
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;

  // funct values for R-type
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // ALU operation select
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110,
    aluSlt = 4'b0111,
    aluNop = 4'b1111
  } aluOp_t;

  // ==============================
  // instruction field layouts
  // ==============================
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rType_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jType_t;

  // one fetched word, seen through all three layouts
  typedef union packed {
    rType_t r;
    iType_t i;
    jType_t j;
  } instrWord_t;

  // datapath controls, 13 bits
  typedef struct packed {
    logic   regDst;
    logic   aluSrc;
    logic   memToReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   jump;
    logic   link;
    logic   branch;
    aluOp_t aluOp;
  } ctrlSig_t;

endpackage

`default_nettype wire

// File: dv/mipsTb.sv
/* MIPS core testbench
   ROM and SRAM models, ISA reference model and a per-cycle checker */
`timescale 1ns/1ns
`default_nettype none

module mipsTb import mipsPkg::*; ();

  localparam int progWords   = 36;
  localparam int resetCycles = 8;
  // every word runs at most once, plus reset and slack
  localparam int timeLimitNs = (progWords + resetCycles + 20) * 40;

  // what one instruction should do
  typedef struct packed {
    logic [31:0] nextPc;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        memAccess;
    logic        store;
    logic [6:0]  memAddr;
    logic [31:0] storeData;
  } refStep_t;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] irAddr;
  logic [31:0] ir;
  logic [31:0] memReadData;
  logic [31:0] memWriteData;
  logic [31:0] rfWriteData;
  logic        memCen;
  logic        memWen;
  logic [6:0]  memAddr;

  logic [31:0] rom [0:255];
  logic [31:0] sram [0:127];
  logic [31:0] refRegs [0:31];
  logic [31:0] refMem [0:127];
  logic [31:0] refPc;
  integer      seed;
  bit          done = 1'b0;

  mipsCore #(.dmemAddrWidth(7)) u_dut (
    .clk          (clk),
    .rst          (rst),
    .irAddr       (irAddr),
    .ir           (ir),
    .memReadData  (memReadData),
    .memCen       (memCen),
    .memWen       (memWen),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .rfWriteData  (rfWriteData)
  );

  always #20 clk = ~clk;

  // ==============================
  // memory models
  // ==============================
  // ROM, word addressed, 1 KB
  assign ir          = rom[irAddr[9:2]];
  assign memReadData = sram[memAddr];

  // SRAM write, both strobes low
  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      sram[memAddr] = memWriteData;
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch against the reference model");
    end
  endtask

  // ==============================
  // ISA reference
  // ==============================
  function automatic refStep_t refExecute(input logic [31:0] pc, input logic [31:0] instr);
    refStep_t    s;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] pc4;
    a   = refRegs[instr[25:21]];
    b   = refRegs[instr[20:16]];
    imm = {{16{instr[15]}}, instr[15:0]};
    ea  = a + imm;
    pc4 = pc + 32'd4;
    s   = '0;
    s.nextPc = pc4;
    case (instr[31:26])
      opR: begin
        s.wbEn   = 1'b1;
        s.wbAddr = instr[15:11];
        case (instr[5:0])
          fnAdd:   s.wbData = a + b;
          fnSub:   s.wbData = a - b;
          fnAnd:   s.wbData = a & b;
          fnOr:    s.wbData = a | b;
          fnSlt:   s.wbData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: s.wbEn = 1'b0;
        endcase
      end
      opLw: begin
        s.memAccess = 1'b1;
        s.memAddr   = ea[8:2];
        s.wbEn      = 1'b1;
        s.wbAddr    = instr[20:16];
        s.wbData    = refMem[ea[8:2]];
      end
      opSw: begin
        s.memAccess = 1'b1;
        s.store     = 1'b1;
        s.memAddr   = ea[8:2];
        s.storeData = b;
      end
      opBeq: begin
        if (a == b) begin
          s.nextPc = pc4 + (imm << 2);
        end
      end
      opJ: s.nextPc = {pc4[31:28], instr[25:0], 2'b00};
      opJal: begin
        s.nextPc = {pc4[31:28], instr[25:0], 2'b00};
        s.wbEn   = 1'b1;
        s.wbAddr = 5'd31;
        s.wbData = pc4;
      end
      // unknown opcode is a bubble
      default: s.wbEn = 1'b0;
    endcase
    return s;
  endfunction

  // ==============================
  // checker, mid-cycle
  // ==============================
  always @(negedge clk) begin
    refStep_t exp;
    string    tag;
    if (!rst) begin
      refPc = 32'd0;
      for (int r = 0; r < 32; r++)
        refRegs[r[4:0]] = '0;
      for (int w = 0; w < 128; w++)
        refMem[w[6:0]] = sram[w[6:0]];
      checkValue("reset irAddr", 32'd0, irAddr);
      checkValue("reset memCen", 32'd1, {31'd0, memCen});
      checkValue("reset memWen", 32'd1, {31'd0, memWen});
    end else if (!done) begin
      exp = refExecute(refPc, rom[refPc[9:2]]);
      tag = $sformatf("pc %08h", refPc);
      checkValue({tag, " irAddr"}, refPc, irAddr);
      checkValue({tag, " memCen"}, {31'd0, !exp.memAccess}, {31'd0, memCen});
      checkValue({tag, " memWen"}, {31'd0, !exp.store}, {31'd0, memWen});
      if (exp.memAccess) begin
        checkValue({tag, " memAddr"}, {25'd0, exp.memAddr}, {25'd0, memAddr});
      end
      if (exp.store) begin
        checkValue({tag, " memWriteData"}, exp.storeData, memWriteData);
        refMem[exp.memAddr] = exp.storeData;
      end
      if (exp.wbEn) begin
        checkValue({tag, " rfWriteData"}, exp.wbData, rfWriteData);
        if (exp.wbAddr != 5'd0) begin
          refRegs[exp.wbAddr] = exp.wbData;
        end
      end
      // self-jump ends the program
      if (exp.nextPc == refPc) begin
        done = 1'b1;
      end
      refPc = exp.nextPc;
    end
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin
    seed = 5;
    rst  = 1'b0;
    for (int w = 0; w < 256; w++)
      rom[w[7:0]] = '0;
    $readmemh("dv/program.hex", rom);
    // low half random, high half tagged by address
    for (int w = 0; w < 128; w++)
      sram[w[6:0]] = (w < 64) ? $random(seed) : (32'hC0DE0000 + w);
    repeat (resetCycles) @(posedge clk);
    #2 rst = 1'b1;
    wait (done);
    @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(timeLimitNs);
    $display("timeout: the program never reached its final self-jump");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: dv/program.hex
// instruction words, two per line, from byte address 0 upward
// columns: word at addr, word at addr+4, then the addr and the mnemonics
AC000100 8C010000  // 00 sw r0,0x100(r0) ; lw r1,0(r0)
8C020004 00221820  // 08 lw r2,4(r0) ; add r3,r1,r2
00012022 00222824  // 10 sub r4,r0,r1 ; and r5,r1,r2
00223025 0081382A  // 18 or r6,r1,r2 ; slt r7,r4,r1
0024402A 0080482A  // 20 slt r8,r1,r4 ; slt r9,r4,r0
00220020 00015025  // 28 add r0,r1,r2 ; or r10,r0,r1
AC030008 AC040104  // 30 sw r3,8(r0) ; sw r4,0x104(r0)
8C0B0008 8C0C0104  // 38 lw r11,8(r0) ; lw r12,0x104(r0)
10220001 11630001  // 40 beq r1,r2,+1 ; beq r11,r3,+1
00216820 08000016  // 48 add r13,r1,r1 (skipped) ; j 0x58
00647020 10000003  // 50 add r14,r3,r4 ; beq r0,r0,+3
1184FFFD 00000000  // 58 beq r12,r4,-3 ; skipped
00000000 0C00001C  // 60 skipped ; jal 0x70
00000000 00000000  // 68 skipped ; skipped
03E07825 FC300010  // 70 or r15,r31,r0 ; bad opcode
0022883F 02119025  // 78 bad funct ; or r18,r16,r17
AC1F0010 8C130010  // 80 sw r31,0x10(r0) ; lw r19,0x10(r0)
006BA02A 08000023  // 88 slt r20,r3,r11 ; j 0x8c (self)

// File: run.sh
#!/usr/bin/env bash
# build the MIPS core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module mipsTb -f all.f &&
./obj_dir/VmipsTb | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run OK" || { echo "run FAILED"; exit 1; }

// File: source/alu.sv
/* 32-bit ALU
   and, or, add, sub and signed slt, with a zero flag */
`timescale 1ns/1ns
`default_nettype none

module alu import mipsPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOp_t      op,
  output logic [31:0] result,
  output logic        zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluSlt:  result = {31'd0, lessThan};
      // nop and anything else
      default: result = '0;
    endcase
  end

  // flag on any zero result, not only sub
  assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// File: source/controlUnit.sv
/* control unit
   main opcode decoder with the ALU operation decode folded in */
`timescale 1ns/1ns
`default_nettype none

module controlUnit import mipsPkg::*; (
  input  instrWord_t instr,
  output ctrlSig_t   ctrl
);

  always_comb begin
    // default is a bubble, nothing written
    ctrl       = '0;
    ctrl.aluOp = aluNop;
    case (instr.r.opcode)
      opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        // funct picks the ALU operation
        case (instr.r.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          // unknown funct, drop the write
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        // return address into r31
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.aluOp = aluNop;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mipsCore.sv
/* single-cycle MIPS core
   datapath top with instruction fetch port and data SRAM port */
`timescale 1ns/1ns
`default_nettype none

module mipsCore import mipsPkg::*; #(
  parameter int dmemAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic [31:0]              irAddr,
  input  logic [31:0]              ir,
  input  logic [31:0]              memReadData,
  output logic                     memCen,
  output logic                     memWen,
  output logic [dmemAddrWidth-1:0] memAddr,
  output logic [31:0]              memWriteData,
  output logic [31:0]              rfWriteData
);

  instrWord_t  instr;
  ctrlSig_t    ctrl;
  logic [31:0] rdDataA;
  logic [31:0] rdDataB;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;
  logic        regWe;

  assign instr  = ir;
  assign irAddr = pc;

  // ==============================
  // decode and operands
  // ==============================
  controlUnit uControl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  regFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .we      (regWe),
    .rdAddrA (instr.r.rs),
    .rdAddrB (instr.r.rt),
    .wrAddr  (wbAddr),
    .wrData  (wbData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  // immediate sign extension
  assign immExt = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign aluB   = ctrl.aluSrc ? immExt : rdDataB;

  alu uAlu (
    .a      (rdDataA),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit uPc (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .zero    (aluZero),
    .instr   (instr),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  // ==============================
  // write-back selection
  // ==============================
  // link overrides both rd/rt and alu/mem
  assign wbAddr = ctrl.link ? 5'd31 : (ctrl.regDst ? instr.r.rd : instr.r.rt);
  assign wbData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? memReadData : aluResult);
  assign regWe  = ctrl.regWrite & rst;
  assign rfWriteData = wbData;

  // data SRAM port, strobes active low
  assign memAddr      = aluResult[dmemAddrWidth+1:2];
  assign memWriteData = rdDataB;
  assign memCen       = ~(rst & (ctrl.memRead | ctrl.memWrite));
  assign memWen       = ~(rst & ctrl.memWrite);

endmodule

`default_nettype wire

// File: source/pcUnit.sv
/* program counter
   pc register with sequential, branch and jump next-pc selection */
`timescale 1ns/1ns
`default_nettype none

module pcUnit import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  ctrlSig_t    ctrl,
  input  logic        zero,
  input  instrWord_t  instr,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] pcReg;
  logic [31:0] nextPc;
  // sign-extended offset, already in bytes
  logic [31:0] branchOffset;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;

  assign pc      = pcReg;
  assign pcPlus4 = pcReg + 32'd4;

  assign branchOffset = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;
  // region bits come from pc+4
  assign jumpTarget   = {pcPlus4[31:28], instr.j.target, 2'b00};

  // jump wins over branch
  always_comb begin
    if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && zero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= nextPc;
    end
  end

endmodule

`default_nettype wire

// File: source/regFile.sv
/* register file
   32 x 32, two combinational read ports, one write port, r0 hardwired to zero */
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB
);

  // r0 has no storage
  logic [31:0] regs [1:31];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int idx = 1; idx < 32; idx++) begin
        regs[idx] <= '0;
      end
    end else if (we && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ==============================
  // read ports
  // ==============================
  // address 0 always reads zero
  assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

`default_nettype wire
